// File: tb.f
+incdir+verilog
verilog/mmuPkg.sv
verilog/tlb.sv
verilog/pmaChecker.sv
verilog/pmpChecker.sv
verilog/mmu.sv
verif/mmu_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the MMU testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f tb.f --top-module mmu_tb -o mmu_sim
./obj_dir/mmu_sim

// File: verif/mmu_tb.sv
// MMU testbench: stimulus table, LFSR page offsets, value check task and expected results
`timescale 1ns/1ps
`default_nettype none
`include "mmu_defines.svh"

module mmu_tb;
  import mmuPkg::*;

  localparam logic [3:0] accR = 4'h8;
  localparam logic [3:0] accW = 4'h4;
  localparam logic [3:0] accX = 4'h2;
  localparam logic [3:0] accA = 4'h1;
  localparam logic [1:0] privU = 2'b00;
  localparam logic [1:0] privS = 2'b01;
  localparam logic [1:0] privM = 2'b11;

  // Row kinds
  localparam int opLookup = 0;
  localparam int opWrite  = 1;
  localparam int opFlush  = 2;

  typedef struct {
    string       name;
    int          op;
    logic        satpMode;
    logic [8:0]  asid;
    logic [1:0]  priv;
    logic [4:0]  st;
    logic        pmpSel;
    logic [31:0] va;
    logic [1:0]  size;
    logic [3:0]  acc;
    logic [31:0] pte;
    logic        mega;
    int          offBits;
    logic [33:0] expPa;
    logic        expHit;
    logic        expMiss;
    logic        expPf;
    logic [5:0]  expFaults;
  } rowT;

  logic                 clk;
  logic                 reset;
  satpT                 satp;
  statusT               status;
  logic [1:0]           privMode;
  logic                 disableTranslation;
  pmpCfgT               pmpCfg [`PMP_ENTRIES-1:0];
  logic [`XLEN-1:0]     pmpAddr [`PMP_ENTRIES-1:0];
  logic [`XLEN-1:0]     virtualAddress;
  logic [1:0]           size;
  accessT               access;
  pteT                  pteWriteVal;
  pageTypeT             pageTypeWriteVal;
  logic                 tlbWrite;
  logic                 tlbFlush;
  logic [`PA_BITS-1:0]  physicalAddress;
  logic                 tlbHit;
  logic                 tlbMiss;
  logic                 tlbPageFault;
  faultT                faults;
  logic                 squashBusAccess;

  rowT         rows[$];
  logic [15:0] lfsrState;

  mmu #(.tlbEntries(4)) UUT (.*);

  // 8 ns clock
  initial clk = 1'b0;
  always #4 clk = ~clk;

  ////////////////////
  // Helpers
  ////////////////////

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] randomBits(input int n);
    logic [31:0] value;
    logic        lsb;
    value = '0;
    for (int i = 0; i < n; i++) begin
      lsb = lfsrState[0];
      lfsrState = lfsrState >> 1;
      if (lsb) begin
        lfsrState = lfsrState ^ 16'hB400;
      end
      value = {value[30:0], lsb};
    end
    return value;
  endfunction

  // PTE from a 22-bit PPN and the flag byte D A G U X W R V
  function automatic logic [31:0] makePte(input logic [21:0] ppn, input logic [7:0] flags);
    return {ppn, 2'b00, flags};
  endfunction

  // No access in flight, so nothing may be reported
  function automatic logic outputsIdle();
    return (tlbHit === 1'b0) && (tlbMiss === 1'b0) && (tlbPageFault === 1'b0) &&
           (faults === 6'h00) && (squashBusAccess === 1'b0);
  endfunction

  task automatic checkValue(input string name, input string what,
                            input logic [33:0] expected, input logic [33:0] actual);
    if (expected !== actual) begin
      $display("mismatch %s %s expected %h actual %h", name, what, expected, actual);
      $display("Errors found");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic addWrite(input string name, input logic [8:0] asid, input logic [31:0] va,
                          input logic [31:0] pte, input logic mega);
    rowT r;
    r = '{name: name, op: opWrite, satpMode: 1'b0, asid: asid, priv: 2'b00, st: 5'h00,
          pmpSel: 1'b0, va: va, size: 2'd0, acc: 4'h0, pte: pte, mega: mega,
          offBits: 0, expPa: 34'h0, expHit: 1'b0, expMiss: 1'b0, expPf: 1'b0,
          expFaults: 6'h00};
    rows.push_back(r);
  endtask

  task automatic addFlush(input string name);
    rowT r;
    r = '{name: name, op: opFlush, satpMode: 1'b0, asid: 9'h0, priv: 2'b00, st: 5'h00,
          pmpSel: 1'b0, va: 32'h0, size: 2'd0, acc: 4'h0, pte: 32'h0, mega: 1'b0,
          offBits: 0, expPa: 34'h0, expHit: 1'b0, expMiss: 1'b0, expPf: 1'b0,
          expFaults: 6'h00};
    rows.push_back(r);
  endtask

  task automatic addLook(input string name, input logic mode, input logic [8:0] asid,
                         input logic [1:0] priv, input logic [4:0] st, input logic pmpSel,
                         input logic [31:0] va, input logic [1:0] sz, input logic [3:0] acc,
                         input int offBits, input logic [33:0] expPa, input logic hit,
                         input logic miss, input logic pf, input logic [5:0] flt);
    rowT r;
    r = '{name: name, op: opLookup, satpMode: mode, asid: asid, priv: priv, st: st,
          pmpSel: pmpSel, va: va, size: sz, acc: acc, pte: 32'h0, mega: 1'b0,
          offBits: offBits, expPa: expPa, expHit: hit, expMiss: miss, expPf: pf,
          expFaults: flt};
    rows.push_back(r);
  endtask

  // Set 0 opens everything, set 1 holds the NAPOT, TOR, NA4 and locked entries
  task automatic applyPmp(input logic sel);
    if (!sel) begin
      pmpCfg[0] = 8'h00;
      pmpCfg[1] = 8'h00;
      pmpCfg[2] = 8'h00;
      pmpCfg[3] = 8'h1F;
      pmpAddr[0] = 32'h0;
      pmpAddr[1] = 32'h0;
      pmpAddr[2] = 32'h0;
      pmpAddr[3] = 32'hFFFF_FFFF;
    end else begin
      // 4 KiB RWX at RAM base
      pmpCfg[0] = 8'h1F;
      pmpAddr[0] = 32'h2000_01FF;
      // Read only up to 0x8001_0000
      pmpCfg[1] = 8'h09;
      pmpAddr[1] = 32'h2000_4000;
      // UART word, read only
      pmpCfg[2] = 8'h11;
      pmpAddr[2] = 32'h0400_0000;
      // Boot ROM locked, execute only
      pmpCfg[3] = 8'h9C;
      pmpAddr[3] = 32'h0000_05FF;
    end
  endtask

  ////////////////////
  // Stimulus table
  ////////////////////

  task automatic buildTable();
    addLook("bare ram read", 0, 1, privS, 5'h00, 0, 32'h8000_0000, 2, accR, 12,
            34'h0_8000_0000, 0, 0, 0, 6'h00);
    addLook("bare unmapped read", 0, 1, privS, 5'h00, 0, 32'h2000_0000, 2, accR, 12,
            34'h0_2000_0000, 0, 0, 0, 6'h02);
    addLook("machine passthrough", 1, 1, privM, 5'h00, 0, 32'h8000_5000, 2, accR, 12,
            34'h0_8000_5000, 0, 0, 0, 6'h00);
    addLook("machine unmapped exec", 1, 1, privM, 5'h00, 0, 32'h2000_0000, 2, accX, 12,
            34'h0_2000_0000, 0, 0, 0, 6'h04);
    addWrite("fill kilo", 1, 32'h4000_0000, makePte(22'h80001, 8'hCF), 1'b0);
    addWrite("fill global", 1, 32'h4000_1000, makePte(22'h80002, 8'hEF), 1'b0);
    addWrite("fill mega", 1, 32'h4040_0000, makePte(22'h80000, 8'hCF), 1'b1);
    addWrite("fill user", 1, 32'h4000_2000, makePte(22'h80003, 8'hD3), 1'b0);
    addLook("hit same asid", 1, 1, privS, 5'h00, 0, 32'h4000_0000, 2, accR, 12,
            34'h0_8000_1000, 1, 0, 0, 6'h00);
    addLook("global other asid", 1, 2, privS, 5'h00, 0, 32'h4000_1000, 2, accR, 12,
            34'h0_8000_2000, 1, 0, 0, 6'h00);
    addLook("nonglobal other asid", 1, 2, privS, 5'h00, 0, 32'h4000_0000, 2, accR, 12,
            34'h0_4000_0000, 0, 1, 0, 6'h02);
    addLook("megapage", 1, 1, privS, 5'h00, 0, 32'h4040_0000, 2, accR, 22,
            34'h0_8000_0000, 1, 0, 0, 6'h00);
    addLook("s read user sum0", 1, 1, privS, 5'h00, 0, 32'h4000_2000, 2, accR, 12,
            34'h0_8000_3000, 1, 0, 1, 6'h00);
    addLook("s read user sum1", 1, 1, privS, 5'h08, 0, 32'h4000_2000, 2, accR, 12,
            34'h0_8000_3000, 1, 0, 0, 6'h00);
    addLook("u read user page", 1, 1, privU, 5'h00, 0, 32'h4000_2000, 2, accR, 12,
            34'h0_8000_3000, 1, 0, 0, 6'h00);
    addLook("u read super page", 1, 1, privU, 5'h00, 0, 32'h4000_0000, 2, accR, 12,
            34'h0_8000_1000, 1, 0, 1, 6'h00);
    addLook("mprv mpp user", 1, 1, privM, 5'h04, 0, 32'h4000_0000, 2, accR, 12,
            34'h0_8000_1000, 1, 0, 1, 6'h00);
    addLook("s write rw page", 1, 1, privS, 5'h00, 0, 32'h4000_0000, 2, accW, 12,
            34'h0_8000_1000, 1, 0, 0, 6'h00);
    // Round robin wraps to slot 0
    addWrite("fill no w", 1, 32'h4000_3000, makePte(22'h80004, 8'hC3), 1'b0);
    addWrite("fill no d", 1, 32'h4000_4000, makePte(22'h80005, 8'h47), 1'b0);
    addWrite("fill exec only", 1, 32'h4000_5000, makePte(22'h80006, 8'hC9), 1'b0);
    addLook("evicted first", 1, 1, privS, 5'h00, 0, 32'h4000_0000, 2, accR, 12,
            34'h0_4000_0000, 0, 1, 0, 6'h02);
    addLook("write no w", 1, 1, privS, 5'h00, 0, 32'h4000_3000, 2, accW, 12,
            34'h0_8000_4000, 1, 0, 1, 6'h00);
    addLook("write no d", 1, 1, privS, 5'h00, 0, 32'h4000_4000, 2, accW, 12,
            34'h0_8000_5000, 1, 0, 1, 6'h00);
    addLook("read no d", 1, 1, privS, 5'h00, 0, 32'h4000_4000, 2, accR, 12,
            34'h0_8000_5000, 1, 0, 0, 6'h00);
    addLook("read exec only", 1, 1, privS, 5'h00, 0, 32'h4000_5000, 2, accR, 12,
            34'h0_8000_6000, 1, 0, 1, 6'h00);
    addLook("read exec only mxr", 1, 1, privS, 5'h10, 0, 32'h4000_5000, 2, accR, 12,
            34'h0_8000_6000, 1, 0, 0, 6'h00);
    addLook("user page kept", 1, 1, privS, 5'h08, 0, 32'h4000_2000, 2, accR, 12,
            34'h0_8000_3000, 1, 0, 0, 6'h00);
    addFlush("flush");
    addLook("flushed user page", 1, 1, privS, 5'h08, 0, 32'h4000_2000, 2, accR, 12,
            34'h0_4000_2000, 0, 1, 0, 6'h02);
    addLook("flushed exec page", 1, 1, privS, 5'h00, 0, 32'h4000_5000, 2, accR, 12,
            34'h0_4000_5000, 0, 1, 0, 6'h02);
    // PMA map
    addLook("uart execute", 0, 0, privM, 5'h00, 0, 32'h1000_0000, 2, accX, 0,
            34'h0_1000_0000, 0, 0, 0, 6'h04);
    addLook("uart 64-bit read", 0, 0, privM, 5'h00, 0, 32'h1000_0000, 3, accR, 0,
            34'h0_1000_0000, 0, 0, 0, 6'h02);
    addLook("uart atomic", 0, 0, privM, 5'h00, 0, 32'h1000_0000, 2, accA, 0,
            34'h0_1000_0000, 0, 0, 0, 6'h01);
    addLook("bootrom write", 0, 0, privM, 5'h00, 0, 32'h0000_1000, 2, accW, 0,
            34'h0_0000_1000, 0, 0, 0, 6'h01);
    addLook("uart word read", 0, 0, privM, 5'h00, 0, 32'h1000_0000, 2, accR, 0,
            34'h0_1000_0000, 0, 0, 0, 6'h00);
    // PMP entries, first address lies in both the NAPOT and the TOR range
    addLook("napot grants write", 0, 0, privS, 5'h00, 1, 32'h8000_0800, 2, accW, 0,
            34'h0_8000_0800, 0, 0, 0, 6'h00);
    addLook("tor denies write", 0, 0, privS, 5'h00, 1, 32'h8000_2000, 2, accW, 0,
            34'h0_8000_2000, 0, 0, 0, 6'h08);
    addLook("tor allows read", 0, 0, privS, 5'h00, 1, 32'h8000_2000, 2, accR, 0,
            34'h0_8000_2000, 0, 0, 0, 6'h00);
    addLook("na4 read", 0, 0, privS, 5'h00, 1, 32'h1000_0000, 2, accR, 0,
            34'h0_1000_0000, 0, 0, 0, 6'h00);
    addLook("na4 write", 0, 0, privS, 5'h00, 1, 32'h1000_0000, 2, accW, 0,
            34'h0_1000_0000, 0, 0, 0, 6'h08);
    addLook("locked m read", 0, 0, privM, 5'h00, 1, 32'h0000_1000, 2, accR, 0,
            34'h0_0000_1000, 0, 0, 0, 6'h10);
    addLook("locked m exec", 0, 0, privM, 5'h00, 1, 32'h0000_1000, 2, accX, 0,
            34'h0_0000_1000, 0, 0, 0, 6'h00);
    addLook("unmatched s read", 0, 0, privS, 5'h00, 1, 32'h8010_0000, 2, accR, 0,
            34'h0_8010_0000, 0, 0, 0, 6'h10);
    addLook("unmatched m read", 0, 0, privM, 5'h00, 1, 32'h8010_0000, 2, accR, 0,
            34'h0_8010_0000, 0, 0, 0, 6'h00);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    rowT         r;
    logic [31:0] offset;
    logic [31:0] vaMask;
    logic [33:0] paMask;
    int          waitCount;
    lfsrState = 16'd5;
    reset = 1'b1;
    satp = '0;
    status = '0;
    privMode = privM;
    disableTranslation = 1'b0;
    virtualAddress = '0;
    size = 2'd0;
    access = '0;
    pteWriteVal = '0;
    pageTypeWriteVal = KILOPAGE;
    tlbWrite = 1'b0;
    tlbFlush = 1'b0;
    applyPmp(1'b0);
    buildTable();
    repeat (10) @(negedge clk);
    reset = 1'b0;
    // Past the first reset-free edge the idle MMU reports nothing
    waitCount = 0;
    do begin
      @(negedge clk);
      waitCount++;
    end while (!outputsIdle() && waitCount < 20);
    if (!outputsIdle()) begin
      $display("Errors found");
      $fatal(1, "MMU outputs not idle after reset");
    end
    foreach (rows[i]) begin
      r = rows[i];
      access = '0;
      satp = '{mode: r.satpMode, asid: r.asid, ppn: 22'h0};
      status = r.st;
      privMode = r.priv;
      applyPmp(r.pmpSel);
      if (r.op == opWrite) begin
        virtualAddress = r.va;
        pteWriteVal = r.pte;
        pageTypeWriteVal = r.mega ? MEGAPAGE : KILOPAGE;
        tlbWrite = 1'b1;
        @(negedge clk);
        tlbWrite = 1'b0;
      end else if (r.op == opFlush) begin
        tlbFlush = 1'b1;
        @(negedge clk);
        tlbFlush = 1'b0;
      end else begin
        // Random page offset joins the expected PPN
        offset = randomBits(r.offBits);
        vaMask = (32'h1 << r.offBits) - 32'h1;
        paMask = (34'h1 << r.offBits) - 34'h1;
        virtualAddress = (r.va & ~vaMask) | offset;
        size = r.size;
        access = r.acc;
        #3;
        checkValue(r.name, "physicalAddress", (r.expPa & ~paMask) | 34'(offset),
                   physicalAddress);
        checkValue(r.name, "tlbHit", 34'(r.expHit), 34'(tlbHit));
        checkValue(r.name, "tlbMiss", 34'(r.expMiss), 34'(tlbMiss));
        checkValue(r.name, "tlbPageFault", 34'(r.expPf), 34'(tlbPageFault));
        checkValue(r.name, "faults", 34'(r.expFaults), 34'(faults));
        checkValue(r.name, "squashBusAccess", 34'(|r.expFaults), 34'(squashBusAccess));
        @(negedge clk);
      end
    end
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/mmu.sv
// MMU top: TLB translation feeding the PMA and PMP checkers, fault merge and bus squash
`timescale 1ns/1ps
`default_nettype none
`include "mmu_defines.svh"

module mmu #(
  parameter int tlbEntries = `TLB_ENTRIES_DEFAULT,
  parameter bit immu = 1'b0
) (
  input  logic                 clk,
  input  logic                 reset,
  // CSR state
  input  mmuPkg::satpT         satp,
  input  mmuPkg::statusT       status,
  input  logic [1:0]           privMode,
  input  logic                 disableTranslation,
  input  mmuPkg::pmpCfgT       pmpCfg [`PMP_ENTRIES-1:0],
  input  logic [`XLEN-1:0]     pmpAddr [`PMP_ENTRIES-1:0],
  // Request
  input  logic [`XLEN-1:0]     virtualAddress,
  input  logic [1:0]           size,
  input  mmuPkg::accessT       access,
  // Walker fill and sfence
  input  mmuPkg::pteT          pteWriteVal,
  input  mmuPkg::pageTypeT     pageTypeWriteVal,
  input  logic                 tlbWrite,
  input  logic                 tlbFlush,
  // Results
  output logic [`PA_BITS-1:0]  physicalAddress,
  output logic                 tlbHit,
  output logic                 tlbMiss,
  output logic                 tlbPageFault,
  output mmuPkg::faultT        faults,
  output logic                 squashBusAccess
);
  import mmuPkg::*;

  faultT pmaFaults;
  faultT pmpFaults;
  logic  pmaSquash;
  logic  pmpSquash;
  // Attributes end here until a cache exists
  logic  cacheable;
  logic  idempotent;
  logic  atomicAllowed;

  ////////////////////
  // Translation
  ////////////////////

  tlb #(
    .tlbEntries(tlbEntries),
    .itlb      (immu)
  ) tlbInst (
    .clk               (clk),
    .reset             (reset),
    .satp              (satp),
    .status            (status),
    .privMode          (privMode),
    .disableTranslation(disableTranslation),
    .virtualAddress    (virtualAddress),
    .access            (access),
    .pteWriteVal       (pteWriteVal),
    .pageTypeWriteVal  (pageTypeWriteVal),
    .tlbWrite          (tlbWrite),
    .tlbFlush          (tlbFlush),
    .physicalAddress   (physicalAddress),
    .tlbHit            (tlbHit),
    .tlbMiss           (tlbMiss),
    .tlbPageFault      (tlbPageFault)
  );

  ////////////////////
  // Physical checks
  ////////////////////

  pmaChecker pmaCheckerInst (
    .physicalAddress(physicalAddress),
    .size           (size),
    .access         (access),
    .pmaFaults      (pmaFaults),
    .pmaSquash      (pmaSquash),
    .cacheable      (cacheable),
    .idempotent     (idempotent),
    .atomicAllowed  (atomicAllowed)
  );

  pmpChecker pmpCheckerInst (
    .physicalAddress(physicalAddress),
    .privMode       (privMode),
    .status         (status),
    .access         (access),
    .pmpCfg         (pmpCfg),
    .pmpAddr        (pmpAddr),
    .pmpFaults      (pmpFaults),
    .pmpSquash      (pmpSquash)
  );

  // Each checker owns its half of the fault struct
  always_comb begin
    faults          = '0;
    faults.pmpInstr = pmpFaults.pmpInstr;
    faults.pmpLoad  = pmpFaults.pmpLoad;
    faults.pmpStore = pmpFaults.pmpStore;
    faults.pmaInstr = pmaFaults.pmaInstr;
    faults.pmaLoad  = pmaFaults.pmaLoad;
    faults.pmaStore = pmaFaults.pmaStore;
  end

  assign squashBusAccess = pmaSquash || pmpSquash;

endmodule

`default_nettype wire

// File: verilog/pmpChecker.sv
// PMP checker: per-entry OFF/TOR/NA4/NAPOT match, priority select and PMP access faults
`timescale 1ns/1ps
`default_nettype none
`include "mmu_defines.svh"

module pmpChecker (
  input  logic [`PA_BITS-1:0] physicalAddress,
  input  logic [1:0]          privMode,
  input  mmuPkg::statusT      status,
  input  mmuPkg::accessT      access,
  input  mmuPkg::pmpCfgT      pmpCfg [`PMP_ENTRIES-1:0],
  input  logic [`XLEN-1:0]    pmpAddr [`PMP_ENTRIES-1:0],
  output mmuPkg::faultT       pmpFaults,
  output logic                pmpSquash
);
  import mmuPkg::*;

  logic [`XLEN-1:0]        wordAddr;
  logic [`PMP_ENTRIES-1:0] entryMatch;
  logic                    anyMatch;
  pmpCfgT                  selCfg;
  logic [1:0]              effPriv;
  logic                    permR;
  logic                    permW;
  logic                    permX;

  // pmpaddr holds PA bits 33:2
  assign wordAddr = physicalAddress[`PA_BITS-1:2];

  // MPRV applies to loads and stores only
  assign effPriv = (status.mprv && !access.execute) ? status.mpp : privMode;

  ////////////////////
  // Entry match
  ////////////////////

  for (genvar i = 0; i < `PMP_ENTRIES; i++) begin : gEntry
    logic [`XLEN-1:0] lowerBound;
    logic [`XLEN-1:0] napotMask;
    logic             torHit;
    logic             na4Hit;
    logic             napotHit;

    // TOR bottom is the previous pmpaddr, zero below entry 0
    if (i == 0) begin : gFirst
      assign lowerBound = '0;
    end else begin : gRest
      assign lowerBound = pmpAddr[i-1];
    end

    // Trailing ones plus the zero above them select the ignored bits
    assign napotMask = pmpAddr[i] ^ (pmpAddr[i] + 1'b1);

    assign torHit   = (wordAddr >= lowerBound) && (wordAddr < pmpAddr[i]);
    assign na4Hit   = wordAddr == pmpAddr[i];
    assign napotHit = (wordAddr & ~napotMask) == (pmpAddr[i] & ~napotMask);

    // OFF never matches
    assign entryMatch[i] = ((pmpCfg[i].a == PMP_TOR) && torHit) ||
                           ((pmpCfg[i].a == PMP_NA4) && na4Hit) ||
                           ((pmpCfg[i].a == PMP_NAPOT) && napotHit);
  end

  ////////////////////
  // Priority and permissions
  ////////////////////

  // Walk down so the lowest index is assigned last
  always_comb begin
    anyMatch = 1'b0;
    selCfg   = '0;
    for (int i = `PMP_ENTRIES - 1; i >= 0; i--) begin
      if (entryMatch[i]) begin
        anyMatch = 1'b1;
        selCfg   = pmpCfg[i];
      end
    end
  end

  always_comb begin
    if (!anyMatch) begin
      // No match: machine passes, S and U are denied
      permR = effPriv == `PRIV_M;
      permW = effPriv == `PRIV_M;
      permX = effPriv == `PRIV_M;
    end else if ((effPriv == `PRIV_M) && !selCfg.l) begin
      // Unlocked entries do not bind machine mode
      permR = 1'b1;
      permW = 1'b1;
      permX = 1'b1;
    end else begin
      permR = selCfg.r;
      permW = selCfg.w;
      permX = selCfg.x;
    end
  end

  always_comb begin
    pmpFaults          = '0;
    pmpFaults.pmpInstr = access.execute && !permX;
    pmpFaults.pmpLoad  = access.read && !permR;
    pmpFaults.pmpStore = (access.write || access.atomic) && !permW;
  end

  assign pmpSquash = pmpFaults.pmpInstr | pmpFaults.pmpLoad | pmpFaults.pmpStore;

endmodule

`default_nettype wire

// File: verilog/pmaChecker.sv
// PMA checker: fixed region decode, region attributes and PMA access faults
`timescale 1ns/1ps
`default_nettype none
`include "mmu_defines.svh"

module pmaChecker (
  input  logic [`PA_BITS-1:0] physicalAddress,
  input  logic [1:0]          size,
  input  mmuPkg::accessT      access,
  output mmuPkg::faultT       pmaFaults,
  output logic                pmaSquash,
  output logic                cacheable,
  output logic                idempotent,
  output logic                atomicAllowed
);

  logic selBootRom;
  logic selUart;
  logic selRam;
  logic readOk;
  logic writeOk;
  logic execOk;
  logic sizeOk;

  ////////////////////
  // Region decode
  ////////////////////

  assign selBootRom = (physicalAddress >= `PMA_BOOTROM_BASE) &&
                      (physicalAddress < (`PMA_BOOTROM_BASE + `PMA_BOOTROM_SIZE));
  assign selUart    = (physicalAddress >= `PMA_UART_BASE) &&
                      (physicalAddress < (`PMA_UART_BASE + `PMA_UART_SIZE));
  assign selRam     = (physicalAddress >= `PMA_RAM_BASE) &&
                      (physicalAddress < (`PMA_RAM_BASE + `PMA_RAM_SIZE));

  // Attributes, all zero outside the map
  assign readOk        = selBootRom | selUart | selRam;
  assign writeOk       = selUart | selRam;
  assign execOk        = selBootRom | selRam;
  assign atomicAllowed = selRam;
  assign cacheable     = selRam;
  assign idempotent    = selBootRom | selRam;

  // UART registers take word or narrower
  assign sizeOk = !selUart || (size <= 2'd2);

  ////////////////////
  // Faults
  ////////////////////

  always_comb begin
    pmaFaults          = '0;
    pmaFaults.pmaInstr = access.execute && !execOk;
    pmaFaults.pmaLoad  = access.read && !(readOk && sizeOk);
    // AMOs report as stores
    pmaFaults.pmaStore = (access.write && !(writeOk && sizeOk)) ||
                         (access.atomic && !(atomicAllowed && sizeOk));
  end

  assign pmaSquash = pmaFaults.pmaInstr | pmaFaults.pmaLoad | pmaFaults.pmaStore;

endmodule

`default_nettype wire

// File: verilog/tlb.sv
// Fully associative Sv32 TLB with ASID and global match, megapages, fill, flush and page faults
`timescale 1ns/1ps
`default_nettype none
`include "mmu_defines.svh"

module tlb #(
  parameter int tlbEntries = `TLB_ENTRIES_DEFAULT,
  parameter bit itlb = 1'b0
) (
  input  logic                 clk,
  input  logic                 reset,
  input  mmuPkg::satpT         satp,
  input  mmuPkg::statusT       status,
  input  logic [1:0]           privMode,
  input  logic                 disableTranslation,
  input  logic [`XLEN-1:0]     virtualAddress,
  input  mmuPkg::accessT       access,
  input  mmuPkg::pteT          pteWriteVal,
  input  mmuPkg::pageTypeT     pageTypeWriteVal,
  input  logic                 tlbWrite,
  input  logic                 tlbFlush,
  output logic [`PA_BITS-1:0]  physicalAddress,
  output logic                 tlbHit,
  output logic                 tlbMiss,
  output logic                 tlbPageFault
);
  import mmuPkg::*;

  localparam int ptrWidth = (tlbEntries > 1) ? $clog2(tlbEntries) : 1;

  tlbEntryT                entries [tlbEntries];
  tlbEntryT                newEntry;
  tlbEntryT                hitEntry;
  logic [ptrWidth-1:0]     replacePtr;
  logic [tlbEntries-1:0]   hitVec;
  logic [19:0]             vpn;
  logic [1:0]              effPriv;
  logic                    effRead;
  logic                    effWrite;
  logic                    effExecute;
  logic                    anyAccess;
  logic                    translate;
  logic                    pageFault;

  assign vpn = virtualAddress[`XLEN-1:12];

  ////////////////////
  // Effective access
  ////////////////////

  // Fetch side sees everything as execute and never uses MPRV
  assign effExecute = itlb ? (|access) : access.execute;
  // AMOs need both read and write rights
  assign effRead    = itlb ? 1'b0 : (access.read | access.atomic);
  assign effWrite   = itlb ? 1'b0 : (access.write | access.atomic);
  assign anyAccess  = |access;

  // MPRV loads and stores run at MPP
  assign effPriv = (!itlb && status.mprv && !access.execute) ? status.mpp : privMode;

  // Sv32 on, not machine, not bypassed
  assign translate = satp.mode && (effPriv != `PRIV_M) && !disableTranslation;

  ////////////////////
  // Fill and flush
  ////////////////////

  // Tag comes from the faulting address and current ASID
  always_comb begin
    newEntry.valid    = pteWriteVal.v;
    newEntry.asid     = satp.asid;
    newEntry.vpn      = vpn;
    newEntry.pageType = pageTypeWriteVal;
    newEntry.ppn1     = pteWriteVal.ppn1;
    newEntry.ppn0     = pteWriteVal.ppn0;
    newEntry.d        = pteWriteVal.d;
    newEntry.a        = pteWriteVal.a;
    newEntry.g        = pteWriteVal.g;
    newEntry.u        = pteWriteVal.u;
    newEntry.x        = pteWriteVal.x;
    newEntry.w        = pteWriteVal.w;
    newEntry.r        = pteWriteVal.r;
  end

  // Only the valid bits are control state
  always_ff @(posedge clk) begin
    if (reset) begin
      replacePtr <= '0;
      for (int i = 0; i < tlbEntries; i++) begin
        entries[i].valid <= 1'b0;
      end
    end else if (tlbFlush) begin
      // Flush wins over a write in the same cycle
      for (int i = 0; i < tlbEntries; i++) begin
        entries[i].valid <= 1'b0;
      end
    end else if (tlbWrite) begin
      entries[replacePtr] <= newEntry;
      // Round robin victim
      if (replacePtr == ptrWidth'(tlbEntries - 1)) begin
        replacePtr <= '0;
      end else begin
        replacePtr <= replacePtr + 1'b1;
      end
    end
  end

  ////////////////////
  // Lookup
  ////////////////////

  // All tags in parallel, megapages ignore VPN0
  always_comb begin
    for (int i = 0; i < tlbEntries; i++) begin
      hitVec[i] = entries[i].valid &&
                  (entries[i].vpn[19:10] == vpn[19:10]) &&
                  ((entries[i].pageType == MEGAPAGE) || (entries[i].vpn[9:0] == vpn[9:0])) &&
                  ((entries[i].asid == satp.asid) || entries[i].g);
    end
  end

  // Lowest matching slot supplies the payload
  always_comb begin
    hitEntry = '0;
    for (int i = tlbEntries - 1; i >= 0; i--) begin
      if (hitVec[i]) begin
        hitEntry = entries[i];
      end
    end
  end

  assign tlbHit  = translate && anyAccess && (|hitVec);
  assign tlbMiss = translate && anyAccess && !(|hitVec);

  // VPN0 passes through on a megapage
  always_comb begin
    if (tlbHit) begin
      physicalAddress = {hitEntry.ppn1,
                         (hitEntry.pageType == MEGAPAGE) ? vpn[9:0] : hitEntry.ppn0,
                         virtualAddress[11:0]};
    end else begin
      physicalAddress = `PA_BITS'(virtualAddress);
    end
  end

  ////////////////////
  // Page faults
  ////////////////////

  always_comb begin
    pageFault = 1'b0;
    if (effExecute && !hitEntry.x) begin
      pageFault = 1'b1;
    end
    // MXR makes execute-only pages readable
    if (effRead && !(hitEntry.r || (status.mxr && hitEntry.x))) begin
      pageFault = 1'b1;
    end
    if (effWrite && (!hitEntry.w || !hitEntry.d)) begin
      pageFault = 1'b1;
    end
    if (!hitEntry.a) begin
      pageFault = 1'b1;
    end
    if ((effPriv == `PRIV_U) && !hitEntry.u) begin
      pageFault = 1'b1;
    end
    // Supervisor never runs user code, reads it only with SUM
    if ((effPriv == `PRIV_S) && hitEntry.u && (effExecute || !status.sum)) begin
      pageFault = 1'b1;
    end
  end

  // A miss goes to the walker, not to the trap logic
  assign tlbPageFault = tlbHit && pageFault;

endmodule

`default_nettype wire

// File: verilog/mmuPkg.sv
// MMU types: PTE, page size, TLB entry, PMP config, access kind, satp, status and fault flags
`default_nettype none

package mmuPkg;

  ////////////////////
  // Page tables
  ////////////////////

  // Sv32 leaf PTE as written by the walker
  typedef struct packed {
    logic [11:0] ppn1;
    logic [9:0]  ppn0;
    logic [1:0]  rsw;
    logic        d;
    logic        a;
    logic        g;
    logic        u;
    logic        x;
    logic        w;
    logic        r;
    logic        v;
  } pteT;

  // Leaf level of the walk
  typedef enum logic {
    KILOPAGE = 1'b0,
    MEGAPAGE = 1'b1
  } pageTypeT;

  // One TLB slot, tag plus the PTE fields needed after the hit
  typedef struct packed {
    logic        valid;
    logic [8:0]  asid;
    logic [19:0] vpn;
    pageTypeT    pageType;
    logic [11:0] ppn1;
    logic [9:0]  ppn0;
    logic        d;
    logic        a;
    logic        g;
    logic        u;
    logic        x;
    logic        w;
    logic        r;
  } tlbEntryT;

  ////////////////////
  // PMP
  ////////////////////

  // Address matching mode
  typedef enum logic [1:0] {
    PMP_OFF   = 2'd0,
    PMP_TOR   = 2'd1,
    PMP_NA4   = 2'd2,
    PMP_NAPOT = 2'd3
  } pmpModeT;

  // One pmpcfg byte
  typedef struct packed {
    logic       l;
    logic [1:0] reserved;
    pmpModeT    a;
    logic       x;
    logic       w;
    logic       r;
  } pmpCfgT;

  ////////////////////
  // Request and CSR views
  ////////////////////

  // Kind of access, more than one bit may be set
  typedef struct packed {
    logic read;
    logic write;
    logic execute;
    logic atomic;
  } accessT;

  typedef struct packed {
    logic        mode;
    logic [8:0]  asid;
    logic [21:0] ppn;
  } satpT;

  // mstatus bits the MMU looks at
  typedef struct packed {
    logic       mxr;
    logic       sum;
    logic       mprv;
    logic [1:0] mpp;
  } statusT;

  // Access faults, PMP half and PMA half
  typedef struct packed {
    logic pmpInstr;
    logic pmpLoad;
    logic pmpStore;
    logic pmaInstr;
    logic pmaLoad;
    logic pmaStore;
  } faultT;

endpackage

`default_nettype wire

// File: verilog/mmu_defines.svh
// Address widths, PMP entry count, default TLB depth, privilege codes and PMA region map
`ifndef MMU_DEFINES_SVH
`define MMU_DEFINES_SVH

////////////////////
// Widths
////////////////////

// Register and virtual address width
`define XLEN 32
// Sv32 physical address width
`define PA_BITS 34

// Number of PMP entries
`define PMP_ENTRIES 4
// TLB depth when the top level does not override it
`define TLB_ENTRIES_DEFAULT 8

// Privilege encodings as held in privMode and MPP
`define PRIV_U 2'b00
`define PRIV_S 2'b01
`define PRIV_M 2'b11

////////////////////
// PMA regions
////////////////////

// Boot ROM, 4 KiB
`define PMA_BOOTROM_BASE 34'h0_0000_1000
`define PMA_BOOTROM_SIZE 34'h0_0000_1000
// UART registers, 256 B
`define PMA_UART_BASE 34'h0_1000_0000
`define PMA_UART_SIZE 34'h0_0000_0100
// Main memory, 256 MiB
`define PMA_RAM_BASE 34'h0_8000_0000
`define PMA_RAM_SIZE 34'h0_1000_0000

`endif
